//--- vlog.f
+incdir+source
source/addr_map_pkg.sv
source/mem_bus_pkg.sv
source/addr_region_decoder.sv
source/rsp_fifo.sv
source/rsp_merge.sv
source/spm_addr_mapper_top.sv
dv/tb_spm_addr_mapper.sv

//--- dv/tb_spm_addr_mapper.sv
// ------------------------------
// Testbench for the SPM address mapper
// Random cores and latency memory models per port
// Scoreboard checks routing, credits and merged responses
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module tb_spm_addr_mapper;

  import addr_map_pkg::*;
  import mem_bus_pkg::*;

  localparam int NP      = `MAP_NUM_PORTS;
  localparam int DEPTH   = `MAP_FIFO_DEPTH;
  localparam int N_REQ   = 120;
  localparam int TIMEOUT = 20000;

  // Memory model entry, cycle of the answer plus payload
  typedef struct packed {
    int    due;
    data_t data;
    user_t user;
  } pend_t;

  logic              clk_i = 1'b0;
  logic              rst_n_i;
  map_cfg_t          cfg;
  mem_req_t [NP-1:0] mem_req = '0;
  mem_rsp_t [NP-1:0] mem_rsp;
  logic     [NP-1:0] error;
  spm_req_t [NP-1:0] spm_req;
  spm_rsp_t [NP-1:0] spm_rsp = '0;
  mem_req_t [NP-1:0] cache_req;
  mem_rsp_t [NP-1:0] cache_rsp = '0;

  int       seed = 74136;
  logic     run = 1'b0;
  int       tick = 0;
  mem_req_t nxt_req [NP] = '{default: '0};
  mem_rsp_t nxt_spm [NP] = '{default: '0};
  mem_rsp_t nxt_cache [NP] = '{default: '0};

  // Scoreboard, indexed by port and tag
  logic  exp_live [NP][256] = '{default: '{default: 1'b0}};
  logic  exp_cache [NP][256];
  data_t exp_data [NP][256];
  int    issued [NP] = '{default: 0};
  int    expected [NP] = '{default: 0};
  int    done [NP] = '{default: 0};
  int    out_spm [NP] = '{default: 0};
  int    out_cache [NP] = '{default: 0};

  // Memory models, entry 2p is SPM and 2p+1 is cache
  pend_t mbuf [2*NP][8];
  int    mhead [2*NP] = '{default: 0};
  int    mcnt [2*NP] = '{default: 0};

  spm_addr_mapper_top spm_addr_mapper_top_i (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg),
    .mem_req_i   (mem_req),
    .mem_rsp_o   (mem_rsp),
    .error_o     (error),
    .spm_req_o   (spm_req),
    .spm_rsp_i   (spm_rsp),
    .cache_req_o (cache_req),
    .cache_rsp_i (cache_rsp)
  );

  always #5 clk_i = ~clk_i;

  // ------------------------------
  // Reference rules
  // ------------------------------
  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int p, input logic [95:0] exp,
                             input logic [95:0] act);
    assert (exp === act)
      else fail_now($sformatf("** Error %s (port %0d): expected %0h, actual %0h",
                              name, p, exp, act));
  endtask

  // Window split: SPM part, hole, everything else to cache
  function automatic route_e predict_route(input addr_t a);
    addr_t spm_top;
    spm_top = cfg.tcdm_start + cfg.spm_size;
    if (a < cfg.tcdm_start || a >= cfg.tcdm_end) begin
      return ROUTE_CACHE;
    end
    if (a < spm_top) begin
      return ROUTE_SPM;
    end
    return ROUTE_ERR;
  endfunction

  // Memory content as a hash of address and tag
  function automatic data_t model_data(input addr_t a, input user_t u);
    return (a * 32'h9e37_79b1) ^ {4{u}};
  endfunction

  // ------------------------------
  // Stimulus and models
  // ------------------------------
  task automatic make_request(input int p, output mem_req_t r);
    addr_t       a;
    addr_t       hole;
    logic [31:0] rnd;
    r = '0;
    // Idle gaps between requests
    if (issued[p] < N_REQ && ($unsigned($random(seed)) % 4) != 0) begin
      hole = cfg.tcdm_end - cfg.tcdm_start - cfg.spm_size;
      case ($unsigned($random(seed)) % 5)
        0, 1: a = cfg.tcdm_start + ($unsigned($random(seed)) % cfg.spm_size);
        2: a = cfg.tcdm_start + cfg.spm_size + ($unsigned($random(seed)) % hole);
        default: begin
          a = $random(seed);
          // Push random hits on the window out of it
          if (predict_route(a) != ROUTE_CACHE) begin
            a = a ^ 32'h4000_0000;
          end
        end
      endcase
      rnd = $random(seed);
      r.q_valid = 1'b1;
      r.q.addr  = a;
      r.q.write = rnd[0];
      r.q.amo   = rnd[7:4];
      r.q.strb  = rnd[11:8];
      r.q.data  = $random(seed);
      r.q.user  = user_t'(issued[p]);
      issued[p]++;
    end
  endtask

  // Random ready, in-order answers 1 to 4 cycles later
  task automatic serve_memory(input int m, input logic accept, input data_t d, input user_t u,
                              output mem_rsp_t rsp);
    int lat;
    lat = 1 + ($unsigned($random(seed)) % 4);
    if (accept) begin
      assert (mcnt[m] < 8) else fail_now("memory model queue overflowed");
      mbuf[m][(mhead[m] + mcnt[m]) % 8] = '{due: tick + lat, data: d, user: u};
      mcnt[m]++;
    end
    rsp = '0;
    rsp.q_ready = ($unsigned($random(seed)) % 3) != 0;
    if (mcnt[m] > 0 && mbuf[m][mhead[m]].due <= tick + 1) begin
      rsp.p_valid = 1'b1;
      rsp.data    = mbuf[m][mhead[m]].data;
      rsp.user    = mbuf[m][mhead[m]].user;
      mhead[m]    = (mhead[m] + 1) % 8;
      mcnt[m]--;
    end
  endtask

  task automatic check_routing(input int p, input mem_req_t req, input route_e route);
    spm_req_chan_t exp_spm;
    exp_spm.addr  = req.q.addr[`MAP_SPM_ADDR_W-1:0];
    exp_spm.write = req.q.write;
    exp_spm.amo   = req.q.amo;
    exp_spm.data  = req.q.data;
    exp_spm.strb  = req.q.strb;
    exp_spm.user  = req.q.user;
    if (!req.q_valid) begin
      assert (!spm_req[p].q_valid && !cache_req[p].q_valid && !error[p])
        else fail_now("memory request or error raised without a core request");
    end else if (route == ROUTE_SPM) begin
      assert (!cache_req[p].q_valid && !error[p])
        else fail_now("SPM request reached the cache or raised an error");
      check_value("spm_payload", p, exp_spm, spm_req[p].q);
      check_value("spm_valid", p, out_spm[p] < DEPTH, spm_req[p].q_valid);
      check_value("spm_ready", p, (out_spm[p] < DEPTH) && spm_rsp[p].q_ready,
                  mem_rsp[p].q_ready);
    end else if (route == ROUTE_CACHE) begin
      assert (!spm_req[p].q_valid && !error[p])
        else fail_now("cache request reached the SPM or raised an error");
      check_value("cache_payload", p, req.q, cache_req[p].q);
      check_value("cache_valid", p, out_cache[p] < DEPTH, cache_req[p].q_valid);
      check_value("cache_ready", p, (out_cache[p] < DEPTH) && cache_rsp[p].q_ready,
                  mem_rsp[p].q_ready);
    end else begin
      assert (!spm_req[p].q_valid && !cache_req[p].q_valid)
        else fail_now("request to the hole reached a memory");
      check_value("err_flag", p, 1'b1, error[p]);
      check_value("err_ready", p, 1'b1, mem_rsp[p].q_ready);
    end
  endtask

  // ------------------------------
  // Scoreboard, sampled mid-cycle
  // ------------------------------
  always @(negedge clk_i) begin
    route_e   route;
    mem_req_t req;
    logic     acc;
    user_t    tag;
    if (run) begin
      for (int p = 0; p < NP; p++) begin
        req   = mem_req[p];
        route = predict_route(req.q.addr);
        // Responses first, a pop frees its slot this cycle
        if (mem_rsp[p].p_valid) begin
          tag = mem_rsp[p].user;
          assert (exp_live[p][tag])
            else fail_now($sformatf("port %0d returned unexpected tag %0d", p, tag));
          check_value("rsp_data", p, exp_data[p][tag], mem_rsp[p].data);
          exp_live[p][tag] = 1'b0;
          done[p]++;
          if (exp_cache[p][tag]) begin
            out_cache[p]--;
          end else begin
            out_spm[p]--;
          end
        end
        check_routing(p, req, route);
        acc = req.q_valid && mem_rsp[p].q_ready;
        if (acc && route != ROUTE_ERR) begin
          tag = req.q.user;
          exp_live[p][tag]  = 1'b1;
          exp_cache[p][tag] = (route == ROUTE_CACHE);
          if (route == ROUTE_SPM) begin
            exp_data[p][tag] = model_data(addr_t'(req.q.addr[`MAP_SPM_ADDR_W-1:0]), tag);
            out_spm[p]++;
          end else begin
            exp_data[p][tag] = model_data(req.q.addr, tag);
            out_cache[p]++;
          end
          expected[p]++;
          assert (out_spm[p] <= DEPTH && out_cache[p] <= DEPTH)
            else fail_now("more requests outstanding than the FIFO depth");
        end
        serve_memory(2 * p, spm_req[p].q_valid && spm_rsp[p].q_ready,
                     model_data(addr_t'(spm_req[p].q.addr), spm_req[p].q.user),
                     spm_req[p].q.user, nxt_spm[p]);
        serve_memory(2 * p + 1, cache_req[p].q_valid && cache_rsp[p].q_ready,
                     model_data(cache_req[p].q.addr, cache_req[p].q.user),
                     cache_req[p].q.user, nxt_cache[p]);
        // Pending request holds until accepted
        nxt_req[p] = req;
        if (!req.q_valid || acc) begin
          make_request(p, nxt_req[p]);
        end
      end
      tick++;
    end
  end

  always @(posedge clk_i) begin
    for (int p = 0; p < NP; p++) begin
      mem_req[p]   <= nxt_req[p];
      spm_rsp[p]   <= nxt_spm[p];
      cache_rsp[p] <= nxt_cache[p];
    end
  end

  function automatic logic ports_finished();
    for (int p = 0; p < NP; p++) begin
      if (issued[p] < N_REQ || nxt_req[p].q_valid || done[p] != expected[p]) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // ------------------------------
  // Sequence
  // ------------------------------
  initial begin
    int   waited;
    logic all_done;
    rst_n_i = 1'b0;
    cfg     = '{tcdm_start: 32'h1000_0000, tcdm_end: 32'h1002_0000, spm_size: 32'h0000_8000};
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;
    // Idle outputs before the first request
    repeat (4) begin
      @(negedge clk_i);
      for (int p = 0; p < NP; p++) begin
        assert (!mem_rsp[p].p_valid && !error[p] && !spm_req[p].q_valid && !cache_req[p].q_valid)
          else fail_now("outputs not idle after reset");
      end
    end
    @(posedge clk_i);
    run <= 1'b1;
    waited   = 0;
    all_done = 1'b0;
    while (!all_done && waited < TIMEOUT) begin
      @(posedge clk_i);
      all_done = ports_finished();
      waited++;
    end
    if (!all_done) begin
      fail_now("timeout waiting for all responses");
    end else begin
      // Late or stray responses still hit the scoreboard
      repeat (30) @(posedge clk_i);
      for (int p = 0; p < NP; p++) begin
        check_value("rsp_count", p, expected[p], done[p]);
        check_value("spm_left", p, 0, out_spm[p]);
        check_value("cache_left", p, 0, out_cache[p]);
      end
      $display("test passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- source/spm_addr_mapper_top.sv
// ------------------------------
// Address mapper between cores and SPM/cache
// One decoder and one response merge per core port
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module spm_addr_mapper_top (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  addr_map_pkg::map_cfg_t                      cfg_i,
  // Core side
  input  mem_bus_pkg::mem_req_t [`MAP_NUM_PORTS-1:0]  mem_req_i,
  output mem_bus_pkg::mem_rsp_t [`MAP_NUM_PORTS-1:0]  mem_rsp_o,
  output logic                  [`MAP_NUM_PORTS-1:0]  error_o,
  // Scratchpad side
  output mem_bus_pkg::spm_req_t [`MAP_NUM_PORTS-1:0]  spm_req_o,
  input  mem_bus_pkg::spm_rsp_t [`MAP_NUM_PORTS-1:0]  spm_rsp_i,
  // Cache side
  output mem_bus_pkg::mem_req_t [`MAP_NUM_PORTS-1:0]  cache_req_o,
  input  mem_bus_pkg::mem_rsp_t [`MAP_NUM_PORTS-1:0]  cache_rsp_i
);

  import mem_bus_pkg::*;

  for (genvar j = 0; j < `MAP_NUM_PORTS; j++) begin : gen_port
    logic     q_ready;
    logic     credit_spm;
    logic     credit_cache;
    logic     issue_spm;
    logic     issue_cache;
    mem_rsp_t merge_rsp;

    // Request steering
    addr_region_decoder addr_region_decoder_i (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .cfg_i           (cfg_i),
      .mem_req_i       (mem_req_i[j]),
      .q_ready_o       (q_ready),
      .error_o         (error_o[j]),
      .spm_req_o       (spm_req_o[j]),
      .spm_q_ready_i   (spm_rsp_i[j].q_ready),
      .cache_req_o     (cache_req_o[j]),
      .cache_q_ready_i (cache_rsp_i[j].q_ready),
      .credit_spm_i    (credit_spm),
      .credit_cache_i  (credit_cache),
      .issue_spm_o     (issue_spm),
      .issue_cache_o   (issue_cache)
    );

    // Response return path
    rsp_merge rsp_merge_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .spm_rsp_i      (spm_rsp_i[j]),
      .cache_rsp_i    (cache_rsp_i[j]),
      .issue_spm_i    (issue_spm),
      .issue_cache_i  (issue_cache),
      .credit_spm_o   (credit_spm),
      .credit_cache_o (credit_cache),
      .core_rsp_o     (merge_rsp)
    );

    // Decoder ready replaces merge's unused field
    assign mem_rsp_o[j] = '{
      q_ready: q_ready,
      p_valid: merge_rsp.p_valid,
      data:    merge_rsp.data,
      user:    merge_rsp.user
    };
  end

endmodule

`default_nettype wire

//--- source/rsp_merge.sv
// ------------------------------
// Merges SPM and cache responses for one core port
// Two FIFOs, round-robin pop, registered output, credits
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module rsp_merge (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  mem_bus_pkg::spm_rsp_t spm_rsp_i,
  input  mem_bus_pkg::mem_rsp_t cache_rsp_i,
  input  logic                  issue_spm_i,
  input  logic                  issue_cache_i,
  output logic                  credit_spm_o,
  output logic                  credit_cache_o,
  output mem_bus_pkg::mem_rsp_t core_rsp_o
);

  import mem_bus_pkg::*;

  localparam int unsigned DEPTH = `MAP_FIFO_DEPTH;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  // Outstanding request count per side
  typedef logic [CNT_W-1:0] cnt_t;

  mem_rsp_t spm_head;
  mem_rsp_t cache_head;
  mem_rsp_t sel_rsp;
  logic     spm_empty;
  logic     spm_full;
  logic     cache_empty;
  logic     cache_full;
  logic     pop_spm;
  logic     pop_cache;
  // 0 favours SPM, 1 favours cache
  logic     rr_q;
  cnt_t     spm_cnt_q;
  cnt_t     cache_cnt_q;
  logic     p_valid_q;
  data_t    data_q;
  user_t    user_q;

  // ------------------------------
  // Response buffering
  // ------------------------------
  rsp_fifo spm_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (spm_rsp_i.p_valid),
    .data_i  (spm_rsp_i),
    .pop_i   (pop_spm),
    .data_o  (spm_head),
    .empty_o (spm_empty),
    .full_o  (spm_full)
  );

  rsp_fifo cache_fifo_i (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .push_i  (cache_rsp_i.p_valid),
    .data_i  (cache_rsp_i),
    .pop_i   (pop_cache),
    .data_o  (cache_head),
    .empty_o (cache_empty),
    .full_o  (cache_full)
  );

  // ------------------------------
  // Round-robin pop
  // ------------------------------
  // Lone non-empty side always wins
  assign pop_spm   = !spm_empty && (cache_empty || !rr_q);
  assign pop_cache = !cache_empty && (spm_empty || rr_q);
  assign sel_rsp   = pop_spm ? spm_head : cache_head;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q        <= 1'b0;
      p_valid_q   <= 1'b0;
      spm_cnt_q   <= '0;
      cache_cnt_q <= '0;
    end else begin
      // Hand priority to the other side after a pop
      if (pop_spm || pop_cache) begin
        rr_q <= pop_spm;
      end
      p_valid_q   <= pop_spm || pop_cache;
      spm_cnt_q   <= spm_cnt_q + cnt_t'(issue_spm_i) - cnt_t'(pop_spm);
      cache_cnt_q <= cache_cnt_q + cnt_t'(issue_cache_i) - cnt_t'(pop_cache);
    end
  end

  // Payload register
  always_ff @(posedge clk_i) begin
    if (pop_spm || pop_cache) begin
      data_q <= sel_rsp.data;
      user_q <= sel_rsp.user;
    end
  end

  // Free slot on each side while below depth
  assign credit_spm_o   = (spm_cnt_q < cnt_t'(DEPTH));
  assign credit_cache_o = (cache_cnt_q < cnt_t'(DEPTH));

  // q_ready comes from the decoder at the top
  assign core_rsp_o = '{q_ready: 1'b0, p_valid: p_valid_q, data: data_q, user: user_q};

  // Every pop matches an issued request
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_spm |-> spm_cnt_q != '0);
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_cache |-> cache_cnt_q != '0);

  // Full FIFO means the side has run out of credit
  assert property (@(posedge clk_i) disable iff (!rst_n_i) spm_full |-> !credit_spm_o);
  assert property (@(posedge clk_i) disable iff (!rst_n_i) cache_full |-> !credit_cache_o);

endmodule

`default_nettype wire

//--- source/rsp_fifo.sv
// ------------------------------
// Register-array FIFO for one memory's responses
// Push on memory p_valid, pop by the merge arbiter
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module rsp_fifo (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  push_i,
  input  mem_bus_pkg::mem_rsp_t data_i,
  input  logic                  pop_i,
  output mem_bus_pkg::mem_rsp_t data_o,
  output logic                  empty_o,
  output logic                  full_o
);

  import mem_bus_pkg::*;

  localparam int unsigned DEPTH = `MAP_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  typedef logic [PTR_W-1:0] ptr_t;
  typedef logic [CNT_W-1:0] cnt_t;

  mem_rsp_t mem_q [DEPTH];
  ptr_t     wr_ptr_q;
  ptr_t     rd_ptr_q;
  cnt_t     count_q;

  // Storage, payload only
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at DEPTH
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr_q + ptr_t'(1);
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr_q + ptr_t'(1);
      end
      count_q <= count_q + cnt_t'(push_i) - cnt_t'(pop_i);
    end
  end

  // Head entry, valid while not empty
  assign data_o  = mem_q[rd_ptr_q];
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == cnt_t'(DEPTH));

  // Credits upstream must keep these from firing
  assert property (@(posedge clk_i) disable iff (!rst_n_i) push_i |-> !full_o);
  assert property (@(posedge clk_i) disable iff (!rst_n_i) pop_i |-> !empty_o);

endmodule

`default_nettype wire

//--- source/addr_region_decoder.sv
// ------------------------------
// Steers one core request to SPM, cache or error
// Purely combinational; clock only feeds the checks
// ------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "mapper_params.svh"

module addr_region_decoder (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  addr_map_pkg::map_cfg_t  cfg_i,
  input  mem_bus_pkg::mem_req_t   mem_req_i,
  output logic                    q_ready_o,
  output logic                    error_o,
  output mem_bus_pkg::spm_req_t   spm_req_o,
  input  logic                    spm_q_ready_i,
  output mem_bus_pkg::mem_req_t   cache_req_o,
  input  logic                    cache_q_ready_i,
  input  logic                    credit_spm_i,
  input  logic                    credit_cache_i,
  output logic                    issue_spm_o,
  output logic                    issue_cache_o
);

  import addr_map_pkg::*;
  import mem_bus_pkg::*;

  addr_t  spm_end;
  route_e route;

  // ------------------------------
  // Region classification
  // ------------------------------
  // First byte past the populated SPM
  assign spm_end = cfg_i.tcdm_start + cfg_i.spm_size;

  always_comb begin
    route = ROUTE_CACHE;
    // Inside TCDM window, split on populated size
    if ((mem_req_i.q.addr >= cfg_i.tcdm_start) && (mem_req_i.q.addr < cfg_i.tcdm_end)) begin
      if (mem_req_i.q.addr < spm_end) begin
        route = ROUTE_SPM;
      end else begin
        route = ROUTE_ERR;
      end
    end
  end

  // ------------------------------
  // Request forwarding
  // ------------------------------
  // SPM gets the low address bits only
  assign spm_req_o.q = '{
    addr:  mem_req_i.q.addr[`MAP_SPM_ADDR_W-1:0],
    write: mem_req_i.q.write,
    amo:   mem_req_i.q.amo,
    data:  mem_req_i.q.data,
    strb:  mem_req_i.q.strb,
    user:  mem_req_i.q.user
  };
  assign spm_req_o.q_valid = mem_req_i.q_valid && (route == ROUTE_SPM) && credit_spm_i;

  // Cache sees the request unchanged
  assign cache_req_o.q       = mem_req_i.q;
  assign cache_req_o.q_valid = mem_req_i.q_valid && (route == ROUTE_CACHE) && credit_cache_i;

  // Ready follows target; no credit means hold
  always_comb begin
    case (route)
      ROUTE_SPM:   q_ready_o = spm_q_ready_i && credit_spm_i;
      ROUTE_CACHE: q_ready_o = cache_q_ready_i && credit_cache_i;
      // Hole access is consumed at once
      default:     q_ready_o = 1'b1;
    endcase
  end

  assign error_o = mem_req_i.q_valid && (route == ROUTE_ERR);

  // Handshake pulses for credit tracking
  assign issue_spm_o   = spm_req_o.q_valid && spm_q_ready_i;
  assign issue_cache_o = cache_req_o.q_valid && cache_q_ready_i;

  // Stalled core request stays valid with its payload
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (mem_req_i.q_valid && !q_ready_o) |=> (mem_req_i.q_valid && $stable(mem_req_i.q)));

endmodule

`default_nettype wire

//--- source/mem_bus_pkg.sv
// ------------------------------
// TCDM-style request/response structs
// Core and cache use the full address, SPM the short one
// ------------------------------

`default_nettype none

`include "mapper_params.svh"

package mem_bus_pkg;

  typedef logic [`MAP_DATA_W-1:0]   data_t;
  typedef logic [`MAP_DATA_W/8-1:0] strb_t;
  typedef logic [`MAP_USER_W-1:0]   user_t;
  // Atomic opcode, passed through untouched
  typedef logic [3:0]               amo_t;

  // Request payload, full address
  typedef struct packed {
    addr_map_pkg::addr_t addr;
    logic                write;
    amo_t                amo;
    data_t               data;
    strb_t               strb;
    user_t               user;
  } mem_req_chan_t;

  // Request with valid, core and cache side
  typedef struct packed {
    mem_req_chan_t q;
    logic          q_valid;
  } mem_req_t;

  // Request payload, SPM address
  typedef struct packed {
    addr_map_pkg::spm_addr_t addr;
    logic                    write;
    amo_t                    amo;
    data_t                   data;
    strb_t                   strb;
    user_t                   user;
  } spm_req_chan_t;

  typedef struct packed {
    spm_req_chan_t q;
    logic          q_valid;
  } spm_req_t;

  // Response; p_valid is a pulse without ready
  typedef struct packed {
    logic  q_ready;
    logic  p_valid;
    data_t data;
    user_t user;
  } mem_rsp_t;

  // SPM answers with the same layout
  typedef mem_rsp_t spm_rsp_t;

endpackage

`default_nettype wire

//--- source/addr_map_pkg.sv
// ------------------------------
// Address types and map configuration for the mapper
// Shared by the decoder, the top level and the bus structs
// ------------------------------

`default_nettype none

`include "mapper_params.svh"

package addr_map_pkg;

  // Full address, core and cache side
  typedef logic [`MAP_ADDR_W-1:0] addr_t;

  // Scratchpad address, low bits only
  typedef logic [`MAP_SPM_ADDR_W-1:0] spm_addr_t;

  // Static window setup
  // spm_size counts bytes from tcdm_start
  typedef struct packed {
    addr_t tcdm_start;
    addr_t tcdm_end;
    addr_t spm_size;
  } map_cfg_t;

  // Decoder target for one request
  typedef enum logic [1:0] {
    ROUTE_SPM,
    ROUTE_CACHE,
    ROUTE_ERR
  } route_e;

endpackage

`default_nettype wire

//--- source/mapper_params.svh
// ------------------------------
// Global sizing for the address mapper
// Include wherever widths, port count or FIFO depth are needed
// ------------------------------

`ifndef MAPPER_PARAMS_SVH
`define MAPPER_PARAMS_SVH

// Full core/cache address width
`define MAP_ADDR_W 32

// SPM address width after truncation
`define MAP_SPM_ADDR_W 16

// Data path width
`define MAP_DATA_W 32

// Tag carried in user field
`define MAP_USER_W 8

// Core ports served
`define MAP_NUM_PORTS 2

// Response entries buffered per memory and port
`define MAP_FIFO_DEPTH 2

`endif
